// File: source/post_unit_pkg.sv
`default_nettype none

package post_unit_pkg;

  ////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////

  // one partial-product lane from the array
  localparam int lane_p_width      = 40;
  // biased sum keeps the low bits of each lane
  localparam int acc_width         = 32;
  localparam int bias_width        = 8;
  localparam int bias_set_width    = 2 * bias_width;
  localparam int num_lanes         = 8;
  localparam int lanes_per_channel = 4;
  localparam int out_lane_width    = 8;
  localparam int beat_width        = num_lanes * lane_p_width;
  localparam int mid_width         = num_lanes * acc_width;
  localparam int out_width         = num_lanes * out_lane_width;

  // signed 8-bit saturation bounds
  localparam int sat_max = 127;
  localparam int sat_min = -128;

  ////////////////////////////////////////
  // configuration fields
  ////////////////////////////////////////

  localparam int mode_width  = 4;
  localparam int shift_width = 5;
  localparam int count_width = 16;

  localparam logic [mode_width-1:0] mode_8x8 = 4'd0;
  localparam logic [mode_width-1:0] mode_1x8 = 4'd1;

  // axi4-lite register map
  localparam int axil_addr_width = 8;
  localparam int axil_data_width = 32;
  localparam int axil_strb_width = axil_data_width / 8;
  localparam logic [1:0] resp_okay = 2'b00;

  localparam logic [axil_addr_width-1:0] reg_ctrl   = 8'h00;
  localparam logic [axil_addr_width-1:0] reg_mode   = 8'h04;
  localparam logic [axil_addr_width-1:0] reg_bias   = 8'h08;
  localparam logic [axil_addr_width-1:0] reg_shift  = 8'h0C;
  localparam logic [axil_addr_width-1:0] reg_count  = 8'h10;
  localparam logic [axil_addr_width-1:0] reg_status = 8'h14;

  ////////////////////////////////////////
  // beat views and control state
  ////////////////////////////////////////

  // two channel halves, ch1 in the upper lanes
  typedef struct packed {
    logic [lanes_per_channel-1:0][lane_p_width-1:0] ch1;
    logic [lanes_per_channel-1:0][lane_p_width-1:0] ch0;
  } chan_view_t;

  typedef union packed {
    logic [num_lanes-1:0][lane_p_width-1:0] flat;
    chan_view_t                             chan;
  } beat_u;

  typedef enum logic [1:0] {
    idle,
    run,
    drain
  } job_state_e;

endpackage

`default_nettype wire

// File: source/lane_stream_if.sv
`timescale 1ns/1ns
`default_nettype none

// valid/ready stream between the two pipeline stages
interface lane_stream_if;
  import post_unit_pkg::*;

  logic                 valid;
  logic                 ready;
  logic                 last;
  logic [mid_width-1:0] data;

  modport source (output valid, output last, output data, input ready);
  modport sink (input valid, input last, input data, output ready);

endinterface

`default_nettype wire

// File: source/axil_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_cfg_regs (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [post_unit_pkg::axil_addr_width-1:0] s_axil_awaddr,
  input  logic                                      s_axil_awvalid,
  output logic                                      s_axil_awready,
  input  logic [post_unit_pkg::axil_data_width-1:0] s_axil_wdata,
  input  logic [post_unit_pkg::axil_strb_width-1:0] s_axil_wstrb,
  input  logic                                      s_axil_wvalid,
  output logic                                      s_axil_wready,
  output logic [1:0]                                s_axil_bresp,
  output logic                                      s_axil_bvalid,
  input  logic                                      s_axil_bready,
  input  logic [post_unit_pkg::axil_addr_width-1:0] s_axil_araddr,
  input  logic                                      s_axil_arvalid,
  output logic                                      s_axil_arready,
  output logic [post_unit_pkg::axil_data_width-1:0] s_axil_rdata,
  output logic [1:0]                                s_axil_rresp,
  output logic                                      s_axil_rvalid,
  input  logic                                      s_axil_rready,
  input  logic                                      busy,
  input  logic                                      done,
  output logic [post_unit_pkg::mode_width-1:0]      cfg_mode,
  output logic [post_unit_pkg::bias_set_width-1:0]  cfg_bias,
  output logic [post_unit_pkg::shift_width-1:0]     cfg_shift,
  output logic [post_unit_pkg::count_width-1:0]     cfg_count,
  output logic                                      start
);
  import post_unit_pkg::*;

  logic                       wr_go;
  logic                       wr_fire;
  logic                       rd_fire;
  logic [axil_data_width-1:0] rd_word;

  // accept a write only once address and data are both present
  assign wr_go   = s_axil_awvalid && s_axil_wvalid && !s_axil_awready && !s_axil_bvalid;
  assign wr_fire = s_axil_awvalid && s_axil_awready;
  assign rd_fire = s_axil_arvalid && s_axil_arready;

  // every access completes with OKAY
  assign s_axil_bresp = resp_okay;
  assign s_axil_rresp = resp_okay;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      s_axil_bvalid  <= 1'b0;
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      s_axil_awready <= wr_go;
      s_axil_wready  <= wr_go;
      if (wr_fire) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      s_axil_arready <= s_axil_arvalid && !s_axil_arready && !s_axil_rvalid;
      if (rd_fire) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_mode  <= '0;
      cfg_bias  <= '0;
      cfg_shift <= '0;
      cfg_count <= '0;
      start     <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_fire) begin
        case (s_axil_awaddr)
          // start is dropped while a job runs
          reg_ctrl: begin
            if (s_axil_wstrb[0] && s_axil_wdata[0] && !busy) begin
              start <= 1'b1;
            end
          end
          reg_mode: begin
            if (s_axil_wstrb[0]) cfg_mode <= s_axil_wdata[mode_width-1:0];
          end
          reg_bias: begin
            if (s_axil_wstrb[0]) cfg_bias[7:0] <= s_axil_wdata[7:0];
            if (s_axil_wstrb[1]) cfg_bias[15:8] <= s_axil_wdata[15:8];
          end
          reg_shift: begin
            if (s_axil_wstrb[0]) cfg_shift <= s_axil_wdata[shift_width-1:0];
          end
          reg_count: begin
            if (s_axil_wstrb[0]) cfg_count[7:0] <= s_axil_wdata[7:0];
            if (s_axil_wstrb[1]) cfg_count[15:8] <= s_axil_wdata[15:8];
          end
          default: begin
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // register reads
  ////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    case (s_axil_araddr)
      reg_mode:   rd_word[mode_width-1:0] = cfg_mode;
      reg_bias:   rd_word[bias_set_width-1:0] = cfg_bias;
      reg_shift:  rd_word[shift_width-1:0] = cfg_shift;
      reg_count:  rd_word[count_width-1:0] = cfg_count;
      reg_status: rd_word[1:0] = {done, busy};
      default:    rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      s_axil_rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: source/job_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module job_ctrl_fsm (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic final_beat,
  input  logic in_fire,
  input  logic out_fire,
  input  logic out_last,
  output logic busy,
  output logic done,
  output logic accept_en,
  output logic count_clear
);
  import post_unit_pkg::*;

  job_state_e state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      done  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state <= run;
            done  <= 1'b0;
          end
        end
        // final counted beat closes the input side
        run: begin
          if (in_fire && final_beat) begin
            state <= drain;
          end
        end
        // wait for the marked beat to leave the pipeline
        drain: begin
          if (out_fire && out_last) begin
            state <= idle;
            done  <= 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  assign busy        = (state != idle);
  assign accept_en   = (state == run);
  assign count_clear = start && (state == idle);

endmodule

`default_nettype wire

// File: source/beat_counter.sv
`timescale 1ns/1ns
`default_nettype none

module beat_counter (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 clear,
  input  logic                                 inc,
  input  logic [post_unit_pkg::count_width-1:0] limit,
  output logic                                 final_beat
);
  import post_unit_pkg::*;

  logic [count_width-1:0] count;
  logic [count_width-1:0] last_index;

  // zero limit behaves as a single beat
  assign last_index = (limit == '0) ? '0 : limit - 1'b1;
  assign final_beat = (count == last_index);

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (inc) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/bias_add_stage.sv
`timescale 1ns/1ns
`default_nettype none

module bias_add_stage (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    in_valid,
  input  post_unit_pkg::beat_u                    in_data,
  input  logic                                    in_last,
  input  logic                                    accept_en,
  input  logic [post_unit_pkg::mode_width-1:0]     mode,
  input  logic [post_unit_pkg::bias_set_width-1:0] bias,
  output logic                                    in_ready,
  lane_stream_if.source                           mid
);
  import post_unit_pkg::*;

  logic                                 advance;
  logic                                 in_fire;
  logic [bias_width-1:0]                bias_lo;
  logic [bias_width-1:0]                bias_hi;
  logic [num_lanes-1:0][acc_width-1:0]  sum;

  // low 32 bits of the lane plus sign-extended bias, wraps
  function automatic logic [acc_width-1:0] add_bias(
    input logic [lane_p_width-1:0] lane,
    input logic [bias_width-1:0]   b
  );
    return lane[acc_width-1:0] + {{(acc_width - bias_width){b[bias_width-1]}}, b};
  endfunction

  assign bias_lo  = bias[bias_width-1:0];
  assign bias_hi  = bias[bias_set_width-1:bias_width];
  assign advance  = !mid.valid || mid.ready;
  assign in_ready = accept_en && advance;
  assign in_fire  = in_valid && in_ready;

  ////////////////////////////////////////
  // lane split per precision mode
  ////////////////////////////////////////

  always_comb begin
    sum = '0;
    case (mode)
      // one shared bias on the lower four lanes
      mode_8x8: begin
        for (int i = 0; i < lanes_per_channel; i++) begin
          sum[i] = add_bias(in_data.flat[i], bias_lo);
        end
      end
      // two channels, each with its own bias byte
      mode_1x8: begin
        for (int i = 0; i < lanes_per_channel; i++) begin
          sum[i] = add_bias(in_data.chan.ch0[i], bias_lo);
          sum[i + lanes_per_channel] = add_bias(in_data.chan.ch1[i], bias_hi);
        end
      end
      default: begin
        sum = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mid.valid <= 1'b0;
    end else if (advance) begin
      mid.valid <= in_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      mid.data <= sum;
      mid.last <= in_last;
    end
  end

endmodule

`default_nettype wire

// File: source/requant_clamp_stage.sv
`timescale 1ns/1ns
`default_nettype none

module requant_clamp_stage (
  input  logic                                 clk,
  input  logic                                 reset,
  lane_stream_if.sink                          mid,
  input  logic [post_unit_pkg::shift_width-1:0] shift,
  output logic                                 out_valid,
  output logic [post_unit_pkg::out_width-1:0]   out_data,
  output logic                                 out_last,
  input  logic                                 out_ready
);
  import post_unit_pkg::*;

  logic                                     advance;
  logic [num_lanes-1:0][acc_width-1:0]      lanes;
  logic [num_lanes-1:0][out_lane_width-1:0] clamped;

  assign advance   = !out_valid || out_ready;
  assign mid.ready = advance;
  assign lanes     = mid.data;

  // arithmetic shift, then saturate to signed 8 bits
  always_comb begin
    logic signed [acc_width-1:0] shifted;
    shifted = '0;
    for (int i = 0; i < num_lanes; i++) begin
      shifted = $signed(lanes[i]) >>> shift;
      if (shifted > sat_max) begin
        clamped[i] = out_lane_width'(sat_max);
      end else if (shifted < sat_min) begin
        clamped[i] = out_lane_width'(sat_min);
      end else begin
        clamped[i] = shifted[out_lane_width-1:0];
      end
    end
  end

  ////////////////////////////////////////
  // output register, held under back-pressure
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= mid.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && mid.valid) begin
      out_data <= clamped;
      out_last <= mid.last;
    end
  end

endmodule

`default_nettype wire

// File: source/post_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module post_unit_top (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [post_unit_pkg::axil_addr_width-1:0] s_axil_awaddr,
  input  logic                                      s_axil_awvalid,
  output logic                                      s_axil_awready,
  input  logic [post_unit_pkg::axil_data_width-1:0] s_axil_wdata,
  input  logic [post_unit_pkg::axil_strb_width-1:0] s_axil_wstrb,
  input  logic                                      s_axil_wvalid,
  output logic                                      s_axil_wready,
  output logic [1:0]                                s_axil_bresp,
  output logic                                      s_axil_bvalid,
  input  logic                                      s_axil_bready,
  input  logic [post_unit_pkg::axil_addr_width-1:0] s_axil_araddr,
  input  logic                                      s_axil_arvalid,
  output logic                                      s_axil_arready,
  output logic [post_unit_pkg::axil_data_width-1:0] s_axil_rdata,
  output logic [1:0]                                s_axil_rresp,
  output logic                                      s_axil_rvalid,
  input  logic                                      s_axil_rready,
  input  logic                                      in_valid,
  output logic                                      in_ready,
  input  logic [post_unit_pkg::beat_width-1:0]      in_data,
  input  logic                                      in_last,
  output logic                                      out_valid,
  input  logic                                      out_ready,
  output logic [post_unit_pkg::out_width-1:0]       out_data,
  output logic                                      out_last
);
  import post_unit_pkg::*;

  logic [mode_width-1:0]     cfg_mode;
  logic [bias_set_width-1:0] cfg_bias;
  logic [shift_width-1:0]    cfg_shift;
  logic [count_width-1:0]    cfg_count;
  logic                      start;
  logic                      busy;
  logic                      done;
  logic                      accept_en;
  logic                      count_clear;
  logic                      final_beat;
  logic                      in_fire;
  logic                      out_fire;
  logic                      beat_last;

  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;
  // counted final beat always carries the last flag
  assign beat_last = in_last || final_beat;

  lane_stream_if mid_stream ();

  axil_cfg_regs u_regs (
    .clk            (clk),
    .reset          (reset),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .busy           (busy),
    .done           (done),
    .cfg_mode       (cfg_mode),
    .cfg_bias       (cfg_bias),
    .cfg_shift      (cfg_shift),
    .cfg_count      (cfg_count),
    .start          (start)
  );

  job_ctrl_fsm u_fsm (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .final_beat  (final_beat),
    .in_fire     (in_fire),
    .out_fire    (out_fire),
    .out_last    (out_last),
    .busy        (busy),
    .done        (done),
    .accept_en   (accept_en),
    .count_clear (count_clear)
  );

  beat_counter u_counter (
    .clk        (clk),
    .reset      (reset),
    .clear      (count_clear),
    .inc        (in_fire),
    .limit      (cfg_count),
    .final_beat (final_beat)
  );

  bias_add_stage u_bias (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (beat_last),
    .accept_en (accept_en),
    .mode      (cfg_mode),
    .bias      (cfg_bias),
    .in_ready  (in_ready),
    .mid       (mid_stream.source)
  );

  requant_clamp_stage u_clamp (
    .clk       (clk),
    .reset     (reset),
    .mid       (mid_stream.sink),
    .shift     (cfg_shift),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: tests/post_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module post_unit_tb;
  import post_unit_pkg::*;

  logic                       clk;
  logic                       reset;
  logic [axil_addr_width-1:0] s_axil_awaddr;
  logic                       s_axil_awvalid;
  logic                       s_axil_awready;
  logic [axil_data_width-1:0] s_axil_wdata;
  logic [axil_strb_width-1:0] s_axil_wstrb;
  logic                       s_axil_wvalid;
  logic                       s_axil_wready;
  logic [1:0]                 s_axil_bresp;
  logic                       s_axil_bvalid;
  logic                       s_axil_bready;
  logic [axil_addr_width-1:0] s_axil_araddr;
  logic                       s_axil_arvalid;
  logic                       s_axil_arready;
  logic [axil_data_width-1:0] s_axil_rdata;
  logic [1:0]                 s_axil_rresp;
  logic                       s_axil_rvalid;
  logic                       s_axil_rready;
  logic                       in_valid;
  logic                       in_ready;
  logic [beat_width-1:0]      in_data;
  logic                       in_last;
  logic                       out_valid;
  logic                       out_ready;
  logic [out_width-1:0]       out_data;
  logic                       out_last;

  integer               seed;
  integer               ready_seed;
  bit                   job_active;
  bit                   backpressure;
  logic [31:0]          rnd;
  logic [31:0]          rd_word;
  logic [31:0]          written [4];
  logic [31:0]          field_mask [4];
  // expected output beats, oldest first
  logic [out_width-1:0] exp_data_q [$];
  logic                 exp_last_q [$];

  post_unit_top dut (
    .clk            (clk),
    .reset          (reset),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_data        (in_data),
    .in_last        (in_last),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_data       (out_data),
    .out_last       (out_last)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
      $display("Errors found");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t ns", what, $time);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////////////////////////
  // axi4-lite master
  ////////////////////////////////////////

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    int t;
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_wstrb   = 4'hf;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    t = 0;
    @(negedge clk);
    while (!s_axil_awready) begin
      t++;
      if (t > 100) report_failure("write address and data were never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b1;
    t = 0;
    @(negedge clk);
    while (!s_axil_bvalid) begin
      t++;
      if (t > 100) report_failure("write response never arrived");
      @(negedge clk);
    end
    check_value("s_axil_bresp", s_axil_bresp, 0);
    @(posedge clk);
    #1;
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    int t;
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    t = 0;
    @(negedge clk);
    while (!s_axil_arready) begin
      t++;
      if (t > 100) report_failure("read address was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b1;
    t = 0;
    @(negedge clk);
    while (!s_axil_rvalid) begin
      t++;
      if (t > 100) report_failure("read data never arrived");
      @(negedge clk);
    end
    data = s_axil_rdata;
    check_value("s_axil_rresp", s_axil_rresp, 0);
    @(posedge clk);
    #1;
    s_axil_rready = 1'b0;
  endtask

  ////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////

  // mix of plain random lanes and values that land near the clamp bounds
  function automatic logic [lane_p_width-1:0] random_lane(input logic [shift_width-1:0] shift);
    logic [lane_p_width-1:0] v;
    logic [31:0]             r;
    longint                  base;
    int                      pick;
    r = $random(seed);
    v[39:32] = r[7:0];
    v[31:0] = $random(seed);
    pick = $unsigned($random(seed)) % 8;
    case (pick)
      0: base = 127;
      1: base = 128;
      2: base = -128;
      3: base = -129;
      default: base = 0;
    endcase
    if (pick < 4) begin
      base = (base <<< shift) + longint'(r[10:8]) - 4;
      v[31:0] = base[31:0];
    end else if (pick == 4) begin
      v[31:0] = 32'h7fffffff;
    end else if (pick == 5) begin
      v[31:0] = 32'h80000000;
    end
    return v;
  endfunction

  function automatic logic [out_width-1:0] expected_out(input beat_u beat,
      input logic [3:0] mode, input logic [15:0] bias, input logic [4:0] shift);
    logic [out_width-1:0]    result;
    logic [lane_p_width-1:0] lane;
    logic [31:0]             sum;
    int                      b;
    bit                      used;
    longint                  val;
    result = '0;
    for (int i = 0; i < num_lanes; i++) begin
      used = 1'b1;
      lane = '0;
      b = 0;
      if (mode == mode_8x8 && i < 4) begin
        lane = beat.flat[i];
        b = $signed(bias[7:0]);
      end else if (mode == mode_1x8 && i < 4) begin
        lane = beat.chan.ch0[i];
        b = $signed(bias[7:0]);
      end else if (mode == mode_1x8) begin
        lane = beat.chan.ch1[i - 4];
        b = $signed(bias[15:8]);
      end else begin
        used = 1'b0;
      end
      if (used) begin
        // 32-bit wrap, then floor division by a power of two
        sum = lane[31:0] + b;
        val = $signed(sum);
        val = val >>> shift;
        if (val > 127) val = 127;
        else if (val < -128) val = -128;
        result[i*8 +: 8] = val[7:0];
      end
    end
    return result;
  endfunction

  task automatic run_job(input logic [3:0] mode, input logic [15:0] bias,
                         input logic [4:0] shift, input int count, input bit gaps);
    beat_u       beat;
    logic [31:0] status;
    int          t;
    int          g;
    axil_write(reg_mode, {28'd0, mode});
    axil_write(reg_bias, {16'd0, bias});
    axil_write(reg_shift, {27'd0, shift});
    axil_write(reg_count, count);
    axil_write(reg_ctrl, 32'd1);
    job_active = 1'b1;
    // busy set and previous done cleared
    axil_read(reg_status, status);
    check_value("status after start", status, 1);
    for (int n = 0; n < count; n++) begin
      for (int i = 0; i < num_lanes; i++) begin
        beat.flat[i] = random_lane(shift);
      end
      if (gaps) begin
        g = $unsigned($random(seed)) % 4;
        in_valid = 1'b0;
        repeat (g) begin
          @(posedge clk);
          #1;
        end
      end
      in_valid = 1'b1;
      in_data  = beat;
      in_last  = (n == count - 1);
      t = 0;
      @(negedge clk);
      while (!in_ready) begin
        t++;
        if (t > 500) report_failure("input beat was never accepted");
        @(negedge clk);
      end
      exp_data_q.push_back(expected_out(beat, mode, bias, shift));
      exp_last_q.push_back(n == count - 1);
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
    @(negedge clk);
    check_value("in_ready after final beat", in_ready, 0);
    t = 0;
    while (exp_data_q.size() != 0) begin
      t++;
      if (t > 2000) report_failure("output beats missing at end of job");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    t = 0;
    status = '0;
    while (!status[1]) begin
      t++;
      if (t > 20) report_failure("status done never set");
      axil_read(reg_status, status);
    end
    check_value("status at job end", status, 2);
  endtask

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  always @(posedge clk) begin
    #1;
    if (backpressure) out_ready = $random(ready_seed) & 1;
    else out_ready = 1'b1;
  end

  // transfers happen at the next rising edge, sampled here while stable
  always @(negedge clk) begin
    if (!reset) begin
      if (in_ready && !job_active) report_failure("in_ready high while the unit is idle");
      if (out_valid && out_ready) begin
        if (exp_data_q.size() == 0) begin
          report_failure("output beat with no input beat pending");
        end else begin
          // unit returns to idle once the marked beat leaves
          if (exp_last_q[0]) job_active = 1'b0;
          check_value("out_data", out_data, exp_data_q.pop_front());
          check_value("out_last", out_last, exp_last_q.pop_front());
        end
      end
    end
  end

  initial begin
    seed           = 32'hff24;
    ready_seed     = seed ^ 32'h3c3c;
    job_active     = 1'b0;
    backpressure   = 1'b0;
    reset          = 1'b1;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    in_valid       = 1'b0;
    in_data        = '0;
    in_last        = 1'b0;
    out_ready      = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // control outputs idle after reset
    @(negedge clk);
    check_value("in_ready", in_ready, 0);
    check_value("out_valid", out_valid, 0);
    check_value("s_axil_awready", s_axil_awready, 0);
    check_value("s_axil_wready", s_axil_wready, 0);
    check_value("s_axil_arready", s_axil_arready, 0);
    check_value("s_axil_bvalid", s_axil_bvalid, 0);
    check_value("s_axil_rvalid", s_axil_rvalid, 0);
    @(posedge clk);
    #1;
    axil_read(reg_status, rd_word);
    check_value("status after reset", rd_word, 0);

    // register readback, mode at 0x04 through count at 0x10
    field_mask[0] = 32'h0000000f;
    field_mask[1] = 32'h0000ffff;
    field_mask[2] = 32'h0000001f;
    field_mask[3] = 32'h0000ffff;
    for (int k = 0; k < 4; k++) begin
      written[k] = $random(seed);
      axil_write(8'h04 + 8'(4 * k), written[k]);
    end
    for (int k = 0; k < 4; k++) begin
      axil_read(8'h04 + 8'(4 * k), rd_word);
      check_value("register readback", rd_word, written[k] & field_mask[k]);
    end
    axil_read(8'h18, rd_word);
    check_value("unmapped register", rd_word, 0);

    rnd = $random(seed);
    run_job(mode_8x8, rnd[15:0], rnd[20:16], 1 + $unsigned($random(seed)) % 20, 1'b0);
    rnd = $random(seed);
    run_job(mode_1x8, rnd[15:0], 5'd0, 1 + $unsigned($random(seed)) % 20, 1'b0);
    rnd = $random(seed);
    run_job(mode_1x8, rnd[15:0], 5'd31, 1 + $unsigned($random(seed)) % 20, 1'b0);

    // stalls on both sides of the pipeline
    backpressure = 1'b1;
    rnd = $random(seed);
    run_job(mode_1x8, rnd[15:0], rnd[20:16], 1 + $unsigned($random(seed)) % 20, 1'b1);
    rnd = $random(seed);
    run_job(mode_8x8, rnd[15:0], rnd[20:16], 1 + $unsigned($random(seed)) % 20, 1'b1);
    backpressure = 1'b0;

    rnd = $random(seed);
    run_job(4'd5, rnd[15:0], rnd[20:16], 1 + $unsigned($random(seed)) % 20, 1'b0);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: post_unit_top.f
source/post_unit_pkg.sv
source/lane_stream_if.sv
source/axil_cfg_regs.sv
source/job_ctrl_fsm.sv
source/beat_counter.sv
source/bias_add_stage.sv
source/requant_clamp_stage.sv
source/post_unit_top.sv
tests/post_unit_tb.sv

// File: Bender.yml
package:
  name: post_unit

sources:
  - source/post_unit_pkg.sv
  - source/lane_stream_if.sv
  - source/axil_cfg_regs.sv
  - source/job_ctrl_fsm.sv
  - source/beat_counter.sv
  - source/bias_add_stage.sv
  - source/requant_clamp_stage.sv
  - source/post_unit_top.sv
  - target: test
    files:
      - tests/post_unit_tb.sv
